//--- logic/pipe_ctrl_pkg.sv
// shared widths, control-bus layout and fixed addresses, imported by every pipeline control unit
package pipe_ctrl_pkg;

    // instruction address width
    localparam int inst_addr_width = 32;

    // register index width for x0..x31
    localparam int reg_addr_width = 5;

    // control bus carries one stall bit and one flush bit
    localparam int cu_bus_width = 2;

    // bit positions inside the control bus
    localparam int cu_stall = 0;
    localparam int cu_flush = 1;

    // address type used for pc, jump target, epc and trap entry
    typedef logic [inst_addr_width-1:0] inst_addr_t;

    // register index as seen by the hazard check
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // stall and flush commands for the pipeline registers
    typedef logic [cu_bus_width-1:0] cu_bus_t;

    // first fetch address after reset
    localparam inst_addr_t reset_pc = 32'h0000_0000;

    // single fixed entry point for the external interrupt
    // no vectored mode, every trap lands here
    localparam inst_addr_t trap_vector = 32'h0000_0100;

endpackage

//--- logic/redirect_if.sv
// redirect and stall bundle from ctrl and clint into pc_reg, instantiated once in the top level
interface redirect_if;

    // forwarded jump from ctrl, already gated against stalls
    logic                       jump_flag;
    pipe_ctrl_pkg::inst_addr_t  jump_addr;

    // stall and flush bits for the pipeline registers
    pipe_ctrl_pkg::cu_bus_t     cu_bus;

    // one-cycle redirect from clint, trap entry or mret
    logic                       int_assert;
    pipe_ctrl_pkg::inst_addr_t  int_addr;

    // ctrl owns the jump and the control bus
    modport ctrl_mp (output jump_flag, output jump_addr, output cu_bus);

    // clint owns the interrupt redirect
    modport clint_mp (output int_assert, output int_addr);

    // pc_reg only listens
    modport pc_mp (
        input jump_flag,
        input jump_addr,
        input cu_bus,
        input int_assert,
        input int_addr
    );

endinterface

//--- logic/ctrl.sv
// pipeline control unit that merges stall requests and gates execute-stage jumps toward pc_reg
module ctrl (
    input  logic                      clk,
    input  logic                      reset_i,

    // from the execute stage
    input  logic                      jump_flag_i,
    input  pipe_ctrl_pkg::inst_addr_t jump_addr_i,
    input  logic                      stall_flag_ex_i,
    // atomic sequence still in flight
    input  logic                      atom_opt_busy_i,

    // from clint
    input  logic                      stall_flag_clint_i,

    // from hdu
    input  logic                      stall_flag_hdu_i,

    // to pc_reg and the pipeline registers
    redirect_if.ctrl_mp               redir_o
);

    import pipe_ctrl_pkg::*;

    // any source asking the front end to wait
    logic any_stall;

    // jump arriving while an atomic op is busy must wait too
    logic atom_stall;

    // forwarded jump after gating
    logic jump_go;

    assign any_stall  = stall_flag_ex_i | stall_flag_hdu_i | stall_flag_clint_i;
    assign atom_stall = atom_opt_busy_i & jump_flag_i;

    // a jump only goes out on a quiet cycle
    // clint stall is in any_stall so a trap entry always beats a jump
    assign jump_go = jump_flag_i & ~any_stall & ~atom_opt_busy_i;

    // target passes through untouched
    assign redir_o.jump_addr = jump_addr_i;
    assign redir_o.jump_flag = jump_go;

    // stall holds fetch and decode
    // clint stall is left out here, it flushes instead
    assign redir_o.cu_bus[cu_stall] = stall_flag_ex_i | stall_flag_hdu_i | atom_stall;

    // flush kills the wrong-path instructions behind a jump or a trap redirect
    // note the flush fires on the raw jump even when pc_reg does not take it yet
    assign redir_o.cu_bus[cu_flush] = (jump_flag_i & ~atom_opt_busy_i) | stall_flag_clint_i;

endmodule

//--- logic/hdu.sv
// load-use hazard detection between decode and execute, raises a stall request toward ctrl
module hdu (
    // source fields of the instruction in decode
    input  pipe_ctrl_pkg::reg_addr_t id_rs1_i,
    input  pipe_ctrl_pkg::reg_addr_t id_rs2_i,
    // decoder says whether each source is really read
    input  logic                     id_rs1_used_i,
    input  logic                     id_rs2_used_i,

    // destination and kind of the instruction in execute
    input  pipe_ctrl_pkg::reg_addr_t ex_rd_i,
    input  logic                     ex_is_load_i,

    // to ctrl
    output logic                     stall_flag_o
);

    import pipe_ctrl_pkg::*;

    // x0 never carries a dependency
    localparam reg_addr_t zero_reg = '0;

    // load in execute that will actually write a register
    logic      ex_load_writes;

    // per-source match against the load destination
    logic      rs1_hit;
    logic      rs2_hit;

    // loads to x0 are dropped by the register file
    assign ex_load_writes = ex_is_load_i & (ex_rd_i != zero_reg);

    // unused source fields may hold junk bits, mask them
    assign rs1_hit = id_rs1_used_i & (id_rs1_i == ex_rd_i);
    assign rs2_hit = id_rs2_used_i & (id_rs2_i == ex_rd_i);

    // one bubble is enough since load data forwards from memory stage
    always_comb begin
        stall_flag_o = 1'b0;
        if (ex_load_writes) begin
            stall_flag_o = rs1_hit | rs2_hit;
        end
    end

endmodule

//--- logic/clint.sv
// core-local interrupt unit for one external interrupt, saves the return pc and handles mret
module clint (
    input  logic                      clk,
    input  logic                      reset_i,

    // external interrupt line and its enable
    input  logic                      irq_i,
    input  logic                      irq_en_i,

    // mret retiring in execute
    input  logic                      mret_i,

    // entry is held off while an atomic op runs
    input  logic                      atom_opt_busy_i,

    // current fetch address, saved on entry
    input  pipe_ctrl_pkg::inst_addr_t pc_i,

    // redirect toward pc_reg
    redirect_if.clint_mp              redir_o,

    // to ctrl
    output logic                      stall_flag_o,

    // trap state for the outside world
    output logic                      in_trap_o,
    output pipe_ctrl_pkg::inst_addr_t epc_o
);

    import pipe_ctrl_pkg::*;

    // trap state and saved return address
    logic       in_trap_q;
    inst_addr_t epc_q;

    // decisions for this cycle
    logic       take_irq;
    logic       do_mret;
    logic       redirect;

    // no nesting, so a pending irq waits while in the handler
    assign take_irq = irq_i & irq_en_i & ~in_trap_q & ~atom_opt_busy_i;

    // mret outside a trap is ignored
    assign do_mret = mret_i & in_trap_q;

    // the two cannot both be high since take_irq needs in_trap low
    assign redirect = take_irq | do_mret;

    // one-cycle pulse, ctrl turns it into a flush
    assign redir_o.int_assert = redirect;
    assign stall_flag_o       = redirect;

    // return address only matters on mret, entry is always the fixed vector
    always_comb begin
        if (do_mret) begin
            redir_o.int_addr = epc_q;
        end else begin
            redir_o.int_addr = trap_vector;
        end
    end

    // state moves at the edge after the decision
    always_ff @(posedge clk) begin
        if (reset_i) begin
            in_trap_q <= 1'b0;
            epc_q     <= '0;
        end else if (take_irq) begin
            // pc of the instruction that has not executed yet
            epc_q     <= pc_i;
            in_trap_q <= 1'b1;
        end else if (do_mret) begin
            // epc kept, handy for debug after return
            in_trap_q <= 1'b0;
        end
    end

    assign in_trap_o = in_trap_q;
    assign epc_o     = epc_q;

endmodule

//--- logic/pc_reg.sv
// program counter register for fetch, picks among trap redirect, jump, stall and pc+4 each cycle
module pc_reg (
    input  logic                      clk,
    input  logic                      reset_i,

    // redirect and stall commands from ctrl and clint
    redirect_if.pc_mp                 redir_i,

    // fetch address
    output pipe_ctrl_pkg::inst_addr_t pc_o
);

    import pipe_ctrl_pkg::*;

    // fixed instruction size, no compressed support
    localparam inst_addr_t pc_step = inst_addr_t'(4);

    // current and next fetch address
    inst_addr_t pc_q;
    inst_addr_t pc_d;

    // stall bit pulled off the control bus
    logic       stall;

    assign stall = redir_i.cu_bus[cu_stall];

    // priority order
    // trap redirect first, it may arrive with a stall or a raw jump
    // then the gated jump, then hold, then sequential
    always_comb begin
        if (redir_i.int_assert) begin
            pc_d = redir_i.int_addr;
        end else if (redir_i.jump_flag) begin
            pc_d = redir_i.jump_addr;
        end else if (stall) begin
            pc_d = pc_q;
        end else begin
            pc_d = pc_q + pc_step;
        end
    end

    // flush does not touch pc, it only clears the pipeline registers
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= reset_pc;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

//--- logic/pipe_ctrl_top.sv
// top level of the pipeline control slice, wires ctrl, hdu, clint and pc_reg behind plain ports
module pipe_ctrl_top (
    input  logic                      clk,
    input  logic                      reset_i,

    // execute stage results
    input  logic                      jump_flag_i,
    input  pipe_ctrl_pkg::inst_addr_t jump_addr_i,
    input  logic                      stall_flag_ex_i,
    input  logic                      atom_opt_busy_i,

    // decode sources for the hazard check
    input  pipe_ctrl_pkg::reg_addr_t  id_rs1_i,
    input  pipe_ctrl_pkg::reg_addr_t  id_rs2_i,
    input  logic                      id_rs1_used_i,
    input  logic                      id_rs2_used_i,

    // execute destination for the hazard check
    input  pipe_ctrl_pkg::reg_addr_t  ex_rd_i,
    input  logic                      ex_is_load_i,

    // interrupt and return
    input  logic                      irq_i,
    input  logic                      irq_en_i,
    input  logic                      mret_i,

    // fetch address and pipeline commands
    output pipe_ctrl_pkg::inst_addr_t pc_o,
    output logic                      stall_o,
    output logic                      flush_o,

    // trap state
    output logic                      in_trap_o,
    output pipe_ctrl_pkg::inst_addr_t epc_o
);

    import pipe_ctrl_pkg::*;

    // stall requests into ctrl
    logic       stall_flag_hdu;
    logic       stall_flag_clint;

    // fetch address, also fed back to clint for epc
    inst_addr_t pc;

    // shared redirect bundle
    redirect_if redir ();

    ctrl u_ctrl (
        .clk                (clk),
        .reset_i            (reset_i),
        .jump_flag_i        (jump_flag_i),
        .jump_addr_i        (jump_addr_i),
        .stall_flag_ex_i    (stall_flag_ex_i),
        .atom_opt_busy_i    (atom_opt_busy_i),
        .stall_flag_clint_i (stall_flag_clint),
        .stall_flag_hdu_i   (stall_flag_hdu),
        .redir_o            (redir)
    );

    hdu u_hdu (
        .id_rs1_i      (id_rs1_i),
        .id_rs2_i      (id_rs2_i),
        .id_rs1_used_i (id_rs1_used_i),
        .id_rs2_used_i (id_rs2_used_i),
        .ex_rd_i       (ex_rd_i),
        .ex_is_load_i  (ex_is_load_i),
        .stall_flag_o  (stall_flag_hdu)
    );

    clint u_clint (
        .clk             (clk),
        .reset_i         (reset_i),
        .irq_i           (irq_i),
        .irq_en_i        (irq_en_i),
        .mret_i          (mret_i),
        .atom_opt_busy_i (atom_opt_busy_i),
        .pc_i            (pc),
        .redir_o         (redir),
        .stall_flag_o    (stall_flag_clint),
        .in_trap_o       (in_trap_o),
        .epc_o           (epc_o)
    );

    pc_reg u_pc_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .redir_i (redir),
        .pc_o    (pc)
    );

    // break the control bus out to plain pins
    assign stall_o = redir.cu_bus[cu_stall];
    assign flush_o = redir.cu_bus[cu_flush];
    assign pc_o    = pc;

endmodule

//--- test/tb_pipe_ctrl.sv
// self-checking random testbench for pipe_ctrl_top, run as the simulation top with vlog.f
module tb_pipe_ctrl;

    import pipe_ctrl_pkg::*;

    // run length
    localparam int clk_period   = 8;
    localparam int reset_cycles = 5;
    localparam int phase_cycles = 400;
    localparam int num_phases   = 5;
    // all phases plus reset plus some slack
    localparam int timeout_time = (num_phases * phase_cycles + reset_cycles + 100) * clk_period;

    logic       clk;
    logic       reset_i;
    logic       jump_flag_i;
    inst_addr_t jump_addr_i;
    logic       stall_flag_ex_i;
    logic       atom_opt_busy_i;
    reg_addr_t  id_rs1_i;
    reg_addr_t  id_rs2_i;
    logic       id_rs1_used_i;
    logic       id_rs2_used_i;
    reg_addr_t  ex_rd_i;
    logic       ex_is_load_i;
    logic       irq_i;
    logic       irq_en_i;
    logic       mret_i;
    inst_addr_t pc_o;
    logic       stall_o;
    logic       flush_o;
    logic       in_trap_o;
    inst_addr_t epc_o;

    // model state, one step behind the inputs
    inst_addr_t m_pc;
    inst_addr_t m_epc;
    logic       m_in_trap;

    // name of the phase now driving the inputs
    string      phase_name;
    logic [15:0] lfsr_state;

    // event counts so a phase cannot pass without exercising its path
    int         n_hazard;
    int         n_jump;
    int         n_entry;
    int         n_return;

    pipe_ctrl_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11, maximal length
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // high with chance 1 in 2**k
    task automatic take_rare(input int k, output logic b);
        logic [31:0] v;
        take_bits(k, v);
        b = (v == ((32'd1 << k) - 32'd1));
    endtask

    // expected commands and next state straight from the control rules
    // events is {hazard stall, forwarded jump, irq taken, mret taken}
    function automatic void ref_step(
        input  logic       jump,
        input  inst_addr_t jaddr,
        input  logic       ex_stall,
        input  logic       atom,
        input  reg_addr_t  rs1,
        input  reg_addr_t  rs2,
        input  logic       rs1_used,
        input  logic       rs2_used,
        input  reg_addr_t  rd,
        input  logic       is_load,
        input  logic       irq,
        input  logic       irq_en,
        input  logic       mret,
        input  inst_addr_t pc,
        input  inst_addr_t epc,
        input  logic       in_trap,
        output logic       stall,
        output logic       flush,
        output inst_addr_t pc_n,
        output inst_addr_t epc_n,
        output logic       in_trap_n,
        output logic [3:0] events
    );
        logic hazard;
        logic take_irq;
        logic do_mret;
        logic trap_redir;
        logic jump_go;
        hazard = is_load && (rd != 5'd0)
                 && ((rs1_used && rs1 == rd) || (rs2_used && rs2 == rd));
        take_irq   = irq && irq_en && !in_trap && !atom;
        do_mret    = mret && in_trap;
        trap_redir = take_irq || do_mret;
        jump_go    = jump && !(ex_stall || hazard || trap_redir) && !atom;
        stall      = ex_stall || hazard || (atom && jump);
        flush      = (jump && !atom) || trap_redir;
        if (do_mret)
            pc_n = epc;
        else if (take_irq)
            pc_n = trap_vector;
        else if (jump_go)
            pc_n = jaddr;
        else if (stall)
            pc_n = pc;
        else
            pc_n = pc + 32'd4;
        epc_n     = take_irq ? pc : epc;
        in_trap_n = take_irq ? 1'b1 : (do_mret ? 1'b0 : in_trap);
        events    = {hazard, jump_go, take_irq, do_mret};
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERROR %s %s expected 0x%08h actual 0x%08h", phase_name, what, exp, act);
        $display("TB FAILED");
        $fatal(1, "output mismatch");
    endtask

    task automatic report_missing(input string what);
        $display("phase never produced %s", what);
        $display("TB FAILED");
        $fatal(1, "stimulus did not reach a path");
    endtask

    // compare at the falling edge, well clear of the input updates
    always @(negedge clk) begin
        logic       e_stall;
        logic       e_flush;
        inst_addr_t n_pc;
        inst_addr_t n_epc;
        logic       n_trap;
        logic [3:0] ev;
        // reset not yet driven counts as reset
        if (reset_i !== 1'b0) begin
            m_pc      = reset_pc;
            m_epc     = '0;
            m_in_trap = 1'b0;
        end else begin
            ref_step(jump_flag_i, jump_addr_i, stall_flag_ex_i, atom_opt_busy_i,
                     id_rs1_i, id_rs2_i, id_rs1_used_i, id_rs2_used_i, ex_rd_i,
                     ex_is_load_i, irq_i, irq_en_i, mret_i, m_pc, m_epc, m_in_trap,
                     e_stall, e_flush, n_pc, n_epc, n_trap, ev);
            assert (pc_o == m_pc) else report_mismatch("pc_o", m_pc, pc_o);
            assert (epc_o == m_epc) else report_mismatch("epc_o", m_epc, epc_o);
            assert (in_trap_o == m_in_trap)
                else report_mismatch("in_trap_o", 32'(m_in_trap), 32'(in_trap_o));
            assert (stall_o == e_stall)
                else report_mismatch("stall_o", 32'(e_stall), 32'(stall_o));
            assert (flush_o == e_flush)
                else report_mismatch("flush_o", 32'(e_flush), 32'(flush_o));
            m_pc      = n_pc;
            m_epc     = n_epc;
            m_in_trap = n_trap;
            n_hazard  = n_hazard + int'(ev[3]);
            n_jump    = n_jump + int'(ev[2]);
            n_entry   = n_entry + int'(ev[1]);
            n_return  = n_return + int'(ev[0]);
        end
    end

    // every request low
    task automatic clear_inputs();
        jump_flag_i     <= 1'b0;
        jump_addr_i     <= '0;
        stall_flag_ex_i <= 1'b0;
        atom_opt_busy_i <= 1'b0;
        id_rs1_i        <= '0;
        id_rs2_i        <= '0;
        id_rs1_used_i   <= 1'b0;
        id_rs2_used_i   <= 1'b0;
        ex_rd_i         <= '0;
        ex_is_load_i    <= 1'b0;
        irq_i           <= 1'b0;
        irq_en_i        <= 1'b0;
        mret_i          <= 1'b0;
    endtask

    task automatic run_phase(input string name, input int mode);
        logic [31:0] r;
        logic        b;
        int          n;
        for (n = 0; n < phase_cycles; n++) begin
            @(posedge clk);
            phase_name = name;
            clear_inputs();
            case (mode)
                1: begin
                    // two-bit register fields so matches and x0 come up often
                    ex_is_load_i <= 1'b1;
                    take_bits(2, r);
                    id_rs1_i <= r[4:0];
                    take_bits(2, r);
                    id_rs2_i <= r[4:0];
                    take_bits(2, r);
                    ex_rd_i <= r[4:0];
                    take_bits(1, r);
                    id_rs1_used_i <= r[0];
                    take_bits(1, r);
                    id_rs2_used_i <= r[0];
                end
                2: begin
                    take_bits(1, r);
                    jump_flag_i <= r[0];
                    take_bits(30, r);
                    jump_addr_i <= {r[29:0], 2'b00};
                    take_rare(2, b);
                    stall_flag_ex_i <= b;
                    take_rare(2, b);
                    atom_opt_busy_i <= b;
                end
                3: begin
                    // irq held high, occasional mret lets it re-enter
                    irq_i    <= 1'b1;
                    irq_en_i <= 1'b1;
                    take_rare(2, b);
                    atom_opt_busy_i <= b;
                    take_rare(3, b);
                    mret_i <= b;
                    take_rare(3, b);
                    jump_flag_i <= b;
                    take_bits(30, r);
                    jump_addr_i <= {r[29:0], 2'b00};
                end
                4: begin
                    irq_en_i <= 1'b1;
                    take_rare(3, b);
                    irq_i <= b;
                    take_rare(2, b);
                    mret_i <= b;
                    take_rare(3, b);
                    atom_opt_busy_i <= b;
                    take_rare(3, b);
                    stall_flag_ex_i <= b;
                end
                default: begin
                    // idle, sequential fetch only
                end
            endcase
        end
    endtask

    initial begin
        lfsr_state = 16'd60001;
        phase_name = "reset_seq";
        n_hazard   = 0;
        n_jump     = 0;
        n_entry    = 0;
        n_return   = 0;
        reset_i    <= 1'b1;
        clear_inputs();
        repeat (reset_cycles) @(posedge clk);
        reset_i <= 1'b0;
        run_phase("reset_seq", 0);
        run_phase("load_use", 1);
        run_phase("jump_gate", 2);
        run_phase("irq_entry", 3);
        run_phase("mret_return", 4);
        // let the last inputs be checked
        @(negedge clk);
        assert (n_hazard > 0) else report_missing("a load-use stall");
        assert (n_jump > 0) else report_missing("a forwarded jump");
        assert (n_entry > 0) else report_missing("an interrupt entry");
        assert (n_return > 0) else report_missing("a return from trap");
        $display("TB PASSED");
        $finish;
    end

    // hard stop if the phases never complete
    initial begin
        #(timeout_time);
        $display("timeout, the test phases did not complete in time");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- vlog.f
logic/pipe_ctrl_pkg.sv
logic/redirect_if.sv
logic/ctrl.sv
logic/hdu.sv
logic/clint.sv
logic/pc_reg.sv
logic/pipe_ctrl_top.sv
test/tb_pipe_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the pipeline control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_pipe_ctrl \
    -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_pipe_ctrl)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
